// ==== logic/br_defines.svh ====
/* widths and sizes shared by the branch path */

`ifndef BR_DEFINES_SVH
`define BR_DEFINES_SVH

// data and address width
`define XLEN        32

// physical register tag width
`define PRF_LEN     6

// reorder buffer tag width
`define ROB_LEN     5

// branch reservation station depth, 4 or 8
`define RS_BR_SIZE  4
`define RS_BR_LEN   $clog2(`RS_BR_SIZE)

`endif

// ==== logic/br_pkg.sv ====
/* branch compare opcodes and the dispatch, station entry and resolve structs */

`default_nettype none

`include "br_defines.svh"

package br_pkg;

    // compare opcodes follow the funct3 field, jump takes a spare code
    typedef enum logic [2:0] {
        BR_EQ   = 3'b000,
        BR_NE   = 3'b001,
        BR_JUMP = 3'b010,   // always taken
        BR_LT   = 3'b100,
        BR_GE   = 3'b101,
        BR_LTU  = 3'b110,
        BR_GEU  = 3'b111
    } br_func_e;

    typedef struct packed {
        logic [`XLEN-1:0]    pc;
        logic [`XLEN-1:0]    npc;
        logic [`PRF_LEN-1:0] opa_tag;
        logic                opa_ready;
        logic [`XLEN-1:0]    opa_value;
        logic [`PRF_LEN-1:0] opb_tag;
        logic                opb_ready;
        logic [`XLEN-1:0]    opb_value;
        logic [`XLEN-1:0]    offset;
        logic                is_jalr;
        br_func_e            func;
        logic [`ROB_LEN-1:0] rob_idx;
        logic                pred_taken;
        logic [`XLEN-1:0]    pred_target;
    } br_dispatch_t;

    // a waiting operand keeps its tag in the low bits of its value
    typedef struct packed {
        logic [`XLEN-1:0]    pc;
        logic [`XLEN-1:0]    npc;
        logic                opa_ready;
        logic [`XLEN-1:0]    opa_value;
        logic                opb_ready;
        logic [`XLEN-1:0]    opb_value;
        logic [`XLEN-1:0]    offset;
        logic                is_jalr;
        br_func_e            func;
        logic [`ROB_LEN-1:0] rob_idx;
        logic                pred_taken;
        logic [`XLEN-1:0]    pred_target;
    } br_entry_t;

    typedef struct packed {
        logic [`ROB_LEN-1:0] rob_idx;
        logic                taken;
        logic [`XLEN-1:0]    target;
        logic                mispredict;
    } br_resolve_t;

endpackage

`default_nettype wire

// ==== logic/br_dispatch.sv ====
/* one-entry dispatch register for branches
   holds an instruction while the station is full and snoops the CDB */

`default_nettype none

`include "br_defines.svh"

module br_dispatch (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 flush,
    input  logic                 in_valid,
    input  br_pkg::br_dispatch_t in_br,
    input  logic                 rs_full,
    input  logic                 cdb_valid,
    input  logic [`PRF_LEN-1:0]  cdb_tag,
    input  logic [`XLEN-1:0]     cdb_value,
    output logic                 stall,
    output logic                 disp_enable,
    output br_pkg::br_dispatch_t disp_br
);
    import br_pkg::*;

    logic         held;     // register occupied
    logic         load;
    br_dispatch_t next_br;

    assign stall       = held && rs_full;
    assign disp_enable = held && !rs_full;   // station writes in this cycle
    assign load        = in_valid && !stall; // empty or draining

    //////////////////////////////////////////////////////////////////////
    // next contents, with a broadcast folded into a waiting operand
    always_comb begin
        next_br = load ? in_br : disp_br;
        if (cdb_valid && !next_br.opa_ready && next_br.opa_tag == cdb_tag) begin
            next_br.opa_ready = 1'b1;
            next_br.opa_value = cdb_value;
        end
        if (cdb_valid && !next_br.opb_ready && next_br.opb_tag == cdb_tag) begin
            next_br.opb_ready = 1'b1;
            next_br.opb_value = cdb_value;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // occupancy
    always_ff @(posedge clock) begin
        if (rst || flush) begin
            held <= 1'b0;
        end else if (load) begin
            held <= 1'b1;
        end else if (disp_enable) begin
            held <= 1'b0;       // drained, nothing behind it
        end
    end

    always_ff @(posedge clock) begin
        disp_br <= next_br;
    end

endmodule

`default_nettype wire

// ==== logic/rs_branch.sv ====
/* branch reservation station with CDB wakeup, lowest-index issue and flush
   one write and one issue per cycle */

`default_nettype none

`include "br_defines.svh"

module rs_branch (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 flush,
    input  logic                 enable,
    input  br_pkg::br_dispatch_t disp_br,
    input  logic                 cdb_valid,
    input  logic [`PRF_LEN-1:0]  cdb_tag,
    input  logic [`XLEN-1:0]     cdb_value,
    output logic                 full,
    output logic                 issue_valid,
    output br_pkg::br_entry_t    issue_entry
);
    import br_pkg::*;

    localparam logic [`RS_BR_LEN:0] full_count = `RS_BR_SIZE;

    br_entry_t                entries [`RS_BR_SIZE];
    logic [`RS_BR_SIZE-1:0]   free;
    logic [`RS_BR_LEN:0]      count;
    logic [`RS_BR_SIZE-1:0]   ready;     // occupied with both operands in
    logic [`RS_BR_LEN-1:0]    free_idx;
    logic [`RS_BR_LEN-1:0]    issue_idx;
    logic                     issue_go;
    br_entry_t                new_entry;

    assign full     = (count == full_count);
    assign issue_go = |ready;

    //////////////////////////////////////////////////////////////////////
    // slot selection, lowest index wins on both sides
    always_comb begin
        free_idx  = '0;
        issue_idx = '0;
        for (int i = `RS_BR_SIZE - 1; i >= 0; i--) begin
            ready[i] = !free[i] && entries[i].opa_ready && entries[i].opb_ready;
            if (free[i]) free_idx = i[`RS_BR_LEN-1:0];
            if (ready[i]) issue_idx = i[`RS_BR_LEN-1:0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // incoming entry, operands from value, same-cycle CDB or tag
    always_comb begin
        new_entry.pc          = disp_br.pc;
        new_entry.npc         = disp_br.npc;
        new_entry.offset      = disp_br.offset;
        new_entry.is_jalr     = disp_br.is_jalr;
        new_entry.func        = disp_br.func;
        new_entry.rob_idx     = disp_br.rob_idx;
        new_entry.pred_taken  = disp_br.pred_taken;
        new_entry.pred_target = disp_br.pred_target;

        if (disp_br.opa_ready) begin
            new_entry.opa_ready = 1'b1;
            new_entry.opa_value = disp_br.opa_value;
        end else if (cdb_valid && disp_br.opa_tag == cdb_tag) begin
            new_entry.opa_ready = 1'b1;
            new_entry.opa_value = cdb_value;
        end else begin
            new_entry.opa_ready = 1'b0;
            new_entry.opa_value = {{(`XLEN - `PRF_LEN){1'b0}}, disp_br.opa_tag};
        end

        if (disp_br.opb_ready) begin
            new_entry.opb_ready = 1'b1;
            new_entry.opb_value = disp_br.opb_value;
        end else if (cdb_valid && disp_br.opb_tag == cdb_tag) begin
            new_entry.opb_ready = 1'b1;
            new_entry.opb_value = cdb_value;
        end else begin
            new_entry.opb_ready = 1'b0;
            new_entry.opb_value = {{(`XLEN - `PRF_LEN){1'b0}}, disp_br.opb_tag};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // control state
    always_ff @(posedge clock) begin
        if (rst || flush) begin
            free        <= '1;
            count       <= '0;
            issue_valid <= 1'b0;
        end else begin
            count <= count + {{`RS_BR_LEN{1'b0}}, enable}
                           - {{`RS_BR_LEN{1'b0}}, issue_go};
            if (enable) free[free_idx] <= 1'b0;
            if (issue_go) free[issue_idx] <= 1'b1; // never the slot being written
            issue_valid <= issue_go;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // payload: write, issue and wakeup
    always_ff @(posedge clock) begin
        if (enable) entries[free_idx] <= new_entry;
        if (issue_go) issue_entry <= entries[issue_idx];

        if (cdb_valid) begin
            for (int t = 0; t < `RS_BR_SIZE; t++) begin
                if (!free[t]) begin     // written slot is still free here
                    if (!entries[t].opa_ready &&
                        entries[t].opa_value[`PRF_LEN-1:0] == cdb_tag) begin
                        entries[t].opa_ready <= 1'b1;
                        entries[t].opa_value <= cdb_value;
                    end
                    if (!entries[t].opb_ready &&
                        entries[t].opb_value[`PRF_LEN-1:0] == cdb_tag) begin
                        entries[t].opb_ready <= 1'b1;
                        entries[t].opb_value <= cdb_value;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/branch_unit.sv ====
/* branch resolution, direction, target and misprediction, one cycle */

`default_nettype none

`include "br_defines.svh"

module branch_unit (
    input  logic                clock,
    input  logic                rst,
    input  logic                flush,
    input  logic                issue_valid,
    input  br_pkg::br_entry_t   issue_entry,
    output logic                res_valid,
    output br_pkg::br_resolve_t res
);
    import br_pkg::*;

    logic [`XLEN-1:0] opa;
    logic [`XLEN-1:0] opb;
    logic [`XLEN-1:0] jump_target;
    logic             taken;
    br_resolve_t      result;

    assign opa = issue_entry.opa_value;
    assign opb = issue_entry.opb_value;

    //////////////////////////////////////////////////////////////////////
    // direction
    always_comb begin
        case (issue_entry.func)
            BR_EQ:   taken = (opa == opb);
            BR_NE:   taken = (opa != opb);
            BR_LT:   taken = ($signed(opa) <  $signed(opb));
            BR_GE:   taken = ($signed(opa) >= $signed(opb));
            BR_LTU:  taken = (opa <  opb);
            BR_GEU:  taken = (opa >= opb);
            BR_JUMP: taken = 1'b1;
            default: taken = 1'b0;      // unused code 3'b011
        endcase
    end

    // jalr base is the register, bit 0 dropped
    assign jump_target = issue_entry.is_jalr
                       ? ((opa + issue_entry.offset) & ~`XLEN'd1)
                       : (issue_entry.pc + issue_entry.offset);

    always_comb begin
        result.rob_idx    = issue_entry.rob_idx;
        result.taken      = taken;
        result.target     = taken ? jump_target : issue_entry.npc;
        result.mispredict = (taken != issue_entry.pred_taken) ||
                            (result.target != issue_entry.pred_target);
    end

    //////////////////////////////////////////////////////////////////////
    // output register
    always_ff @(posedge clock) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= issue_valid && !flush; // drop what is issuing at flush
        end
    end

    always_ff @(posedge clock) begin
        if (issue_valid) res <= result;
    end

endmodule

`default_nettype wire

// ==== logic/branch_top.sv ====
/* branch path top, dispatch register, reservation station and branch unit */

`default_nettype none

`include "br_defines.svh"

module branch_top (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 flush,
    input  logic                 in_valid,
    input  br_pkg::br_dispatch_t in_br,
    input  logic                 cdb_valid,
    input  logic [`PRF_LEN-1:0]  cdb_tag,
    input  logic [`XLEN-1:0]     cdb_value,
    output logic                 stall,
    output logic                 res_valid,
    output br_pkg::br_resolve_t  res
);
    import br_pkg::*;

    logic         disp_enable;
    br_dispatch_t disp_br;
    logic         rs_full;
    logic         issue_valid;
    br_entry_t    issue_entry;

    br_dispatch u_dispatch (
        .clock       (clock),
        .rst         (rst),
        .flush       (flush),
        .in_valid    (in_valid),
        .in_br       (in_br),
        .rs_full     (rs_full),
        .cdb_valid   (cdb_valid),
        .cdb_tag     (cdb_tag),
        .cdb_value   (cdb_value),
        .stall       (stall),
        .disp_enable (disp_enable),
        .disp_br     (disp_br)
    );

    rs_branch u_rs (
        .clock       (clock),
        .rst         (rst),
        .flush       (flush),
        .enable      (disp_enable),
        .disp_br     (disp_br),
        .cdb_valid   (cdb_valid),
        .cdb_tag     (cdb_tag),
        .cdb_value   (cdb_value),
        .full        (rs_full),
        .issue_valid (issue_valid),
        .issue_entry (issue_entry)
    );

    branch_unit u_bu (
        .clock       (clock),
        .rst         (rst),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue_entry (issue_entry),
        .res_valid   (res_valid),
        .res         (res)
    );

endmodule

`default_nettype wire

// ==== bench/branch_properties.sv ====
/* concurrent checks on the branch reservation station count, full flag and issue strobe */

`default_nettype none

`include "br_defines.svh"

module branch_properties (
    input logic                   clock,
    input logic                   rst,
    input logic                   flush,
    input logic                   enable,
    input logic                   full,
    input logic                   issue_valid,
    input logic [`RS_BR_LEN:0]    count,
    input logic [`RS_BR_SIZE-1:0] free
);

    // count and full follow the occupied slots
    full_flag_a: assert property (@(posedge clock) disable iff (rst)
        (count == $countones(~free)) && (full == (free == '0)))
    else begin
        $error("station count %0d or full flag disagrees with the free mask", count);
        branch_tb.errors++;
    end

    no_write_when_full_a: assert property (@(posedge clock) disable iff (rst)
        !(enable && full))
    else begin
        $error("station written while full");
        branch_tb.errors++;
    end

    no_issue_after_flush_a: assert property (@(posedge clock) disable iff (rst)
        flush |=> !issue_valid)  // flush drops the issue register too
    else begin
        $error("issue strobe in the cycle after flush");
        branch_tb.errors++;
    end

endmodule

`default_nettype wire

// ==== bench/branch_tb.sv ====
/* testbench for the branch path with random branches, a CDB model,
   reference resolution and a result checker */

`default_nettype none

`include "br_defines.svh"

module branch_tb;
    import br_pkg::*;

    localparam int timeout_cycles = 64;

    logic                clock;
    logic                rst;
    logic                flush;
    logic                in_valid;
    br_dispatch_t        in_br;
    logic                cdb_valid;
    logic [`PRF_LEN-1:0] cdb_tag;
    logic [`XLEN-1:0]    cdb_value;
    logic                stall;
    logic                res_valid;
    br_resolve_t         res;

    br_resolve_t         expected [2**`ROB_LEN];   // by rob tag
    logic                pending  [2**`ROB_LEN];
    logic [`XLEN-1:0]    reg_val  [2**`PRF_LEN];   // value each tag broadcasts
    logic [`ROB_LEN-1:0] next_rob;
    logic [`PRF_LEN-1:0] next_tag;
    int                  outstanding;
    int                  errors;
    int                  results;
    int                  tests;
    int                  test_errors;
    int                  test_results;
    string               test_name;
    br_func_e            func_list [7] = '{BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JUMP};

    branch_top DUT (
        .clock     (clock),
        .rst       (rst),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_br     (in_br),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_value (cdb_value),
        .stall     (stall),
        .res_valid (res_valid),
        .res       (res)
    );

    bind rs_branch branch_properties u_props (
        .clock       (clock),
        .rst         (rst),
        .flush       (flush),
        .enable      (enable),
        .full        (full),
        .issue_valid (issue_valid),
        .count       (count),
        .free        (free)
    );

    always #2 clock = ~clock;

    //////////////////////////////////////////////////////////////////////
    // reference resolution
    function automatic br_resolve_t resolve_ref(br_dispatch_t b, logic [`XLEN-1:0] a,
                                                logic [`XLEN-1:0] c);
        logic             lt_u;
        logic             lt_s;
        logic             take;
        logic [`XLEN-1:0] sum;
        br_resolve_t      r;
        lt_u = a < c;
        lt_s = (a[`XLEN-1] != c[`XLEN-1]) ? a[`XLEN-1] : lt_u;  // differing signs decide alone
        case (b.func)
            BR_EQ:   take = (a == c);
            BR_NE:   take = (a != c);
            BR_LT:   take = lt_s;
            BR_GE:   take = !lt_s;
            BR_LTU:  take = lt_u;
            BR_GEU:  take = !lt_u;
            BR_JUMP: take = 1'b1;
            default: take = 1'b0;
        endcase
        sum          = b.is_jalr ? a + b.offset : b.pc + b.offset;
        r.rob_idx    = b.rob_idx;
        r.taken      = take;
        r.target     = !take ? b.npc : {sum[`XLEN-1:1], sum[0] & !b.is_jalr};
        r.mispredict = (take != b.pred_taken) || (r.target != b.pred_target);
        return r;
    endfunction

    // random branch with both operands ready
    function automatic br_dispatch_t build_branch(br_func_e f, logic jalr,
                                                  logic [`XLEN-1:0] a, logic [`XLEN-1:0] c);
        br_dispatch_t     b;
        logic [`XLEN-1:0] off;
        logic [31:0]      rnd;
        off         = $urandom;
        rnd         = $urandom;
        b           = '0;
        b.pc        = $urandom & ~32'h3;
        b.npc       = b.pc + 4;
        b.opa_ready = 1'b1;
        b.opa_value = a;
        b.opb_ready = 1'b1;
        b.opb_value = c;
        b.offset    = {{(`XLEN-12){off[11]}}, off[11:1], off[0] & jalr}; // odd only for jalr
        b.is_jalr   = jalr;
        b.func      = f;
        b.rob_idx   = next_rob;
        b.pred_taken = rnd[0];
        case (rnd[2:1])
            2'd0:    b.pred_target = b.npc;
            2'd1:    b.pred_target = $urandom;
            default: b.pred_target = b.pc + b.offset;
        endcase
        return b;
    endfunction

    function automatic logic [`PRF_LEN-1:0] alloc_tag(logic [`XLEN-1:0] value);
        next_tag = next_tag + 1;    // fresh tag per waiting operand
        reg_val[next_tag] = value;
        return next_tag;
    endfunction

    function automatic br_dispatch_t hold_operand(br_dispatch_t b, logic on_b,
                                                  logic [`PRF_LEN-1:0] tag);
        br_dispatch_t h;
        h = b;
        if (on_b) begin
            h.opb_ready = 1'b0;
            h.opb_tag   = tag;
            h.opb_value = $urandom;     // stale value that the broadcast replaces
        end else begin
            h.opa_ready = 1'b0;
            h.opa_tag   = tag;
            h.opa_value = $urandom;
        end
        return h;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // result checker
    always @(negedge clock) begin : check_results
        br_resolve_t e;
        if (!rst && res_valid) begin
            e = expected[res.rob_idx];
            assert (pending[res.rob_idx])
            else begin
                $display("unexpected result for rob tag %0d in test %s", res.rob_idx, test_name);
                errors++;
            end
            if (pending[res.rob_idx]) begin
                assert (res == e)
                else begin
                    $display("FAILED %s rob %0d expected %b/%h/%b actual %b/%h/%b",
                             test_name, res.rob_idx, e.taken, e.target, e.mispredict,
                             res.taken, res.target, res.mispredict);
                    errors++;
                end
                pending[res.rob_idx] = 1'b0;
                outstanding--;
                results++;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    task automatic next_cycle(output logic was_stall);
        @(negedge clock);
        was_stall = stall;          // registered level is stable at the falling edge
        @(posedge clock);
        #1;
    endtask

    task automatic end_run();
        $display("%0d tests, %0d results checked, %0d errors", tests, results, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    task automatic give_up(string what);
        $display("timeout %s in test %s", what, test_name);
        errors++;
        end_run();
    endtask

    task automatic dispatch_branch(br_dispatch_t b, logic [`XLEN-1:0] a, logic [`XLEN-1:0] c);
        logic st;
        int   n;
        expected[b.rob_idx] = resolve_ref(b, a, c);
        pending[b.rob_idx]  = 1'b1;
        outstanding++;
        next_rob++;
        in_valid = 1'b1;
        in_br    = b;
        st = 1'b1;
        n  = 0;
        while (st) begin            // held until a cycle without stall
            next_cycle(st);
            cdb_valid = 1'b0;       // one broadcast per cycle
            n++;
            if (n > timeout_cycles) give_up("waiting for dispatch to take a branch");
        end
        in_valid = 1'b0;
    endtask

    task automatic broadcast(logic [`PRF_LEN-1:0] tag, output logic st);
        cdb_valid = 1'b1;
        cdb_tag   = tag;
        cdb_value = reg_val[tag];
        next_cycle(st);
        cdb_valid = 1'b0;
    endtask

    task automatic wait_drain();
        logic st;
        int   n;
        n = 0;
        while (outstanding != 0) begin
            next_cycle(st);
            n++;
            if (n > timeout_cycles) give_up("waiting for outstanding branches to resolve");
        end
    endtask

    task automatic start_test(string name);
        test_name    = name;
        test_errors  = errors;
        test_results = results;
    endtask

    task automatic finish_test();
        wait_drain();
        $display("test %-14s %0d results, %0d errors", test_name,
                 results - test_results, errors - test_errors);
        tests++;
    endtask

    task automatic flush_all();
        logic st;
        flush = 1'b1;
        next_cycle(st);
        flush = 1'b0;
        for (int i = 0; i < 2**`ROB_LEN; i++) begin
            pending[i] = 1'b0;      // whatever was in flight is gone
        end
        outstanding = 0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    initial begin
        logic                st;
        int                  n;
        logic [`XLEN-1:0]    a;
        logic [`XLEN-1:0]    c;
        logic [`PRF_LEN-1:0] t0;
        logic [`PRF_LEN-1:0] t1;
        logic [`PRF_LEN-1:0] tags [`RS_BR_SIZE+1];
        br_dispatch_t        b;
        void'($urandom(32'hf7d9));
        clock       = 1'b0;
        rst         = 1'b1;
        flush       = 1'b0;
        in_valid    = 1'b0;
        in_br       = '0;
        cdb_valid   = 1'b0;
        cdb_tag     = '0;
        cdb_value   = '0;
        next_rob    = '0;
        next_tag    = '0;
        outstanding = 0;
        errors      = 0;
        results     = 0;
        tests       = 0;
        test_name   = "reset";
        for (int i = 0; i < 2**`ROB_LEN; i++) begin
            pending[i] = 1'b0;
        end
        repeat (2) @(posedge clock);
        #1;
        rst = 1'b0;

        // every compare with equal, sign-flipped and random operand pairs
        start_test("ready_operands");
        for (int i = 0; i < 21; i++) begin
            a = $urandom;
            case (i % 3)
                0:       c = a;
                1:       c = a ^ 32'h8000_0000;
                default: c = $urandom;
            endcase
            dispatch_branch(build_branch(func_list[i % 7], 1'b0, a, c), a, c);
        end
        finish_test();

        start_test("jumps");
        for (int i = 0; i < 8; i++) begin
            a = $urandom;
            c = $urandom;
            dispatch_branch(build_branch(BR_JUMP, i[0], a, c), a, c);  // odd i is jalr
        end
        finish_test();

        start_test("wakeup");
        a  = $urandom;
        c  = $urandom;
        t0 = alloc_tag(a);
        b  = hold_operand(build_branch(func_list[$urandom % 7], 1'b0, a, c), 1'b0, t0);
        dispatch_branch(b, a, c);
        repeat (3) next_cycle(st);
        broadcast(t0, st);
        // broadcast while the input is taken
        a  = $urandom;
        c  = $urandom;
        t0 = alloc_tag(c);
        b  = hold_operand(build_branch(func_list[$urandom % 7], 1'b0, a, c), 1'b1, t0);
        cdb_valid = 1'b1;
        cdb_tag   = t0;
        cdb_value = c;
        dispatch_branch(b, a, c);
        // broadcast while the station writes it
        a  = $urandom;
        c  = $urandom;
        t0 = alloc_tag(a);
        b  = hold_operand(build_branch(func_list[$urandom % 7], 1'b0, a, c), 1'b0, t0);
        dispatch_branch(b, a, c);
        broadcast(t0, st);
        // both operands waiting and a second waiter on the same tag
        a  = $urandom;
        c  = $urandom;
        t0 = alloc_tag(a);
        t1 = alloc_tag(c);
        b  = hold_operand(build_branch(func_list[$urandom % 7], 1'b0, a, c), 1'b0, t0);
        dispatch_branch(hold_operand(b, 1'b1, t1), a, c);
        c  = $urandom;
        b  = hold_operand(build_branch(func_list[$urandom % 7], 1'b0, a, c), 1'b0, t0);
        dispatch_branch(b, a, c);
        broadcast(t1, st);
        broadcast(t0, st);
        finish_test();

        // station fills and the last branch stays in the dispatch register
        start_test("full_station");
        for (int i = 0; i <= `RS_BR_SIZE; i++) begin
            a       = $urandom;
            c       = $urandom;
            tags[i] = alloc_tag(a);
            b = hold_operand(build_branch(func_list[i % 7], 1'b0, a, c), 1'b0, tags[i]);
            dispatch_branch(b, a, c);
        end
        st = 1'b0;
        n  = 0;
        while (!st) begin
            next_cycle(st);
            n++;
            if (n > timeout_cycles) give_up("waiting for stall with the station full");
        end
        broadcast(tags[`RS_BR_SIZE], st);
        assert (st)
        else begin
            $display("stall dropped while the station was still full");
            errors++;
        end
        for (int i = 0; i < `RS_BR_SIZE; i++) begin
            broadcast(tags[i], st);
        end
        for (int i = 0; i < 2; i++) begin
            a = $urandom;
            c = $urandom;
            dispatch_branch(build_branch(func_list[$urandom % 7], 1'b0, a, c), a, c);
        end
        finish_test();

        start_test("flush");
        a = $urandom;
        c = $urandom;
        dispatch_branch(build_branch(func_list[$urandom % 7], 1'b0, a, c), a, c);
        for (int i = 0; i < 2; i++) begin
            a       = $urandom;
            c       = $urandom;
            tags[i] = alloc_tag(a);
            b = hold_operand(build_branch(func_list[$urandom % 7], 1'b0, a, c), 1'b0, tags[i]);
            dispatch_branch(b, a, c);
        end
        next_cycle(st);
        flush_all();                // first branch is in the result register by now
        broadcast(tags[0], st);     // old tags find nothing to wake
        broadcast(tags[1], st);
        repeat (4) next_cycle(st);
        a  = $urandom;
        c  = $urandom;
        dispatch_branch(build_branch(func_list[$urandom % 7], 1'b0, a, c), a, c);
        t0 = alloc_tag(c);
        b  = hold_operand(build_branch(func_list[$urandom % 7], 1'b0, a, c), 1'b1, t0);
        dispatch_branch(b, a, c);
        broadcast(t0, st);
        finish_test();

        end_run();
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+logic
logic/br_pkg.sv
logic/br_dispatch.sv
logic/rs_branch.sv
logic/branch_unit.sv
logic/branch_top.sv
bench/branch_properties.sv
bench/branch_tb.sv
